// ==== src.f ====
src/scdPkg.sv
src/scdDecode.sv
src/scadAlu.sv
src/scdRegs.sv
src/pcFlags.sv
src/scdCore.sv
tests/scdCore_assert.sv
tests/scdTb.sv

// ==== Makefile ====
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP       := scdTb
FILELIST  := src.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
RUN_FLAGS := +verilator+error+limit+100
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) $(RUN_FLAGS) > $(LOG) 2>&1
	cat $(LOG)
	grep -q '^TEST OK$$' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== tests/scdTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module scdTb;

  localparam int clkPeriod = 40;
  localparam int resetCycles = 10;
  localparam int perCode = 16;
  localparam int randomCycles = 1500;
  localparam int tailCycles = 20;
  localparam int testCycles = 2 * resetCycles + 8 * perCode + randomCycles + tailCycles + 4;

  logic                             clk;
  logic                             rst;
  logic [scdPkg::funcWidth-1:0]     scadFunc;
  logic [scdPkg::scadaSelWidth-1:0] scadaSel;
  logic [scdPkg::scadbSelWidth-1:0] scadbSel;
  logic                             scSel, scmAlt, feLoad, condFeShrt;
  logic                             condAdFlags, condPcfMagic, condArExp;
  logic                             specFlagCtl, specClrFpd, piCycle;
  scdPkg::magicT                    magic;
  logic [0:scdPkg::arWidth-1]       ar;
  logic                             adOverflow, adCry0, adCry1;
  logic [0:scdPkg::scadWidth-1]     scad, fe, sc;
  logic                             scadZero, scGe36, sc36To63;
  logic                             ov, cry0, cry1, fov, fxu, divChk, fpd;

  scdCore u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  // Random microword; opsOnly keeps operands on FE, SC or magic
  task automatic driveMicroword(input logic [2:0] func, input bit opsOnly);
    logic [31:0] r;
    logic [31:0] s;
    r = $urandom;
    s = $urandom;
    scadFunc = func;
    scadaSel = r[2:0];
    scadbSel = r[4:3];
    scSel = r[5];
    scmAlt = r[6];
    feLoad = r[7];
    condFeShrt = r[8];
    condAdFlags = r[9];
    condPcfMagic = r[10] & r[11];
    condArExp = r[12];
    specFlagCtl = r[13] & r[14] & r[15];
    specClrFpd = r[16] & r[17];
    piCycle = r[18] & r[19];
    adOverflow = r[20];
    adCry0 = r[21];
    adCry1 = r[22];
    magic.value = r[31:23];
    ar = {s[3:0], $urandom};
    if (opsOnly) begin
      scadaSel = s[4] ? scdPkg::scadaMagic : scdPkg::scadaFe;
      scadbSel = s[5] ? scdPkg::scadbMagic : scdPkg::scadbSc;
    end
  endtask

  initial begin
    int code;
    int k;
    logic [31:0] r;
    void'($urandom(32'h3441_8377));
    rst = 1'b1;
    driveMicroword(3'd0, 1'b0);
    repeat (resetCycles) @(negedge clk);
    rst = 1'b0;
    for (code = 0; code < 8; code++) begin
      for (k = 0; k < perCode; k++) begin
        @(negedge clk);
        driveMicroword(3'(code), 1'b1);
      end
    end
    for (k = 0; k < randomCycles; k++) begin
      @(negedge clk);
      r = $urandom;
      driveMicroword(r[2:0], 1'b0);
    end
    // Reset again in the middle of traffic
    @(negedge clk);
    rst = 1'b1;
    repeat (resetCycles) @(negedge clk);
    rst = 1'b0;
    for (k = 0; k < tailCycles; k++) begin
      @(negedge clk);
      r = $urandom;
      driveMicroword(r[2:0], 1'b0);
    end
    repeat (2) @(negedge clk);
    if (u_dut.uChk.failCount != 0) begin
      abortRun("An assertion on the DUT outputs failed");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

  initial begin
    wait (u_dut.uChk.failCount != 0);
    abortRun($sformatf("[ERROR] %s got 0x%h expected 0x%h", u_dut.uChk.failName,
                       u_dut.uChk.failGot, u_dut.uChk.failExp));
  end

  initial begin
    #(testCycles * clkPeriod + 1000);
    abortRun("Timeout: the run did not finish within its cycle budget");
  end

endmodule

`default_nettype wire

// ==== tests/scdCore_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module scdCore_assert (
  input logic                             clk, rst, scSel, scmAlt, feLoad, condFeShrt,
  input logic                             condAdFlags, condPcfMagic, condArExp, piCycle,
  input logic                             specFlagCtl, specClrFpd, adOverflow, adCry0, adCry1,
  input logic                             scadZero, scGe36, sc36To63,
  input logic                             ov, cry0, cry1, fov, fxu, divChk, fpd,
  input logic [scdPkg::funcWidth-1:0]     scadFunc,
  input logic [scdPkg::scadaSelWidth-1:0] scadaSel,
  input logic [scdPkg::scadbSelWidth-1:0] scadbSel,
  input scdPkg::magicT                    magic,
  input logic [0:scdPkg::arWidth-1]       ar,
  input logic [0:scdPkg::scadWidth-1]     scad, fe, sc
);

  int          failCount = 0;
  string       failName = "";
  logic [31:0] failGot = '0;
  logic [31:0] failExp = '0;

  logic [9:0]  magicExt;
  logic [9:0]  opA;
  logic [9:0]  opB;
  logic [10:0] aExt;
  logic [10:0] bExt;
  // Bit 10 is the sign extension and bit 8 is SCAD bit 1
  logic [10:0] res;
  logic [9:0]  feModel;
  logic [9:0]  scModel;
  logic [1:0]  rangeModel;
  // OV CRY0 CRY1 FOV FXU DIV_CHK FPD from the top down
  logic [6:0]  flagModel;
  logic [6:0]  flagSet;

  always_comb begin
    magicExt = {magic.value[0], magic.value};
    case (scadaSel)
      scdPkg::scadaFe:    opA = feModel;
      scdPkg::scadaPos:   opA = {4'b0, ar[0:5]};
      scdPkg::scadaExp:   opA = {2'b0, ar[1:8] ^ {8{ar[0]}}};
      scdPkg::scadaMagic: opA = magicExt;
      default:            opA = '0;
    endcase
    case (scadbSel)
      scdPkg::scadbSc:     opB = scModel;
      scdPkg::scadbSize:   opB = {4'b0, ar[6:11]};
      scdPkg::scadbArLeft: opB = {ar[0], ar[0:8]};
      default:             opB = magicExt;
    endcase
    aExt = {opA[9], opA};
    bExt = {opB[9], opB};
    case (scadFunc)
      scdPkg::fnA:     res = aExt;
      scdPkg::fnAmBm1: res = aExt - bExt - 11'd1;
      scdPkg::fnApB:   res = aExt + bExt;
      scdPkg::fnAm1:   res = aExt - 11'd1;
      scdPkg::fnAp1:   res = aExt + 11'd1;
      scdPkg::fnAmB:   res = aExt - bExt;
      scdPkg::fnOr:    res = aExt | bExt;
      default:         res = aExt & bExt;
    endcase
    // SC of 64 or more and the low six bits in the 36 to 63 window
    rangeModel = {scModel >= 10'd64, scModel[5:0] >= 6'd36};
    flagSet[6] = ((condAdFlags & adOverflow) | (condArExp & res[8])
                  | (condPcfMagic & magic.flags.ovSet)) & ~piCycle;
    flagSet[5] = condAdFlags & adCry0 & ~piCycle;
    flagSet[4] = condAdFlags & adCry1 & ~piCycle;
    flagSet[3] = ((condArExp & res[8]) | (condPcfMagic & magic.flags.ovSet)) & ~piCycle;
    flagSet[2] = ((condArExp & res[10]) | (condPcfMagic & magic.flags.fxuSet)) & ~piCycle;
    flagSet[1] = condPcfMagic & magic.flags.divChkSet & ~piCycle;
    flagSet[0] = condPcfMagic & magic.flags.fpdSet & ~piCycle;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      feModel <= '0;
      scModel <= '0;
      flagModel <= '0;
    end else begin
      if (feLoad) begin
        feModel <= res[9:0];
      end else if (condFeShrt) begin
        feModel <= {feModel[9], feModel[9:1]};
      end
      case ({scSel, scmAlt})
        scdPkg::scmFe:   scModel <= feModel;
        scdPkg::scmScad: scModel <= res[9:0];
        scdPkg::scmAr:   scModel <= ar[26:35];
        default:         scModel <= scModel;
      endcase
      if (specFlagCtl & magic.flags.loadFlagsSel) begin
        flagModel <= {ar[0], ar[1], ar[2], ar[3], ar[11], ar[12], ar[4]};
      end else begin
        flagModel <= {flagModel[6:1] | flagSet[6:1],
                      flagSet[0] | (flagModel[0] & ~specClrFpd)};
      end
    end
  end

  task automatic recordFailure(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    failCount++;
    failName = name;
    failGot = got;
    failExp = exp;
  endtask

  scadValue: assert property (@(posedge clk) disable iff (rst) scad == res[9:0])
    else begin
      recordFailure("scad", 32'($sampled(scad)), 32'($sampled(res[9:0])));
      $error("scad differs from the selected function");
    end

  zeroTest: assert property (@(posedge clk) disable iff (rst)
      scadZero == (res[9:0] == 10'd0))
    else begin
      recordFailure("scadZero", 32'($sampled(scadZero)), 32'($sampled(res[9:0] == 10'd0)));
      $error("scadZero disagrees with the SCAD model");
    end

  feValue: assert property (@(posedge clk) disable iff (rst) fe == feModel)
    else begin
      recordFailure("fe", 32'($sampled(fe)), 32'($sampled(feModel)));
      $error("fe mismatch");
    end

  scValue: assert property (@(posedge clk) disable iff (rst) sc == scModel)
    else begin
      recordFailure("sc", 32'($sampled(sc)), 32'($sampled(scModel)));
      $error("sc mismatch");
    end

  scRange: assert property (@(posedge clk) disable iff (rst)
      {scGe36, sc36To63} == rangeModel)
    else begin
      recordFailure("scGe36,sc36To63", 32'($sampled({scGe36, sc36To63})),
                    32'($sampled(rangeModel)));
      $error("SC range tests mismatch");
    end

  flagValue: assert property (@(posedge clk) disable iff (rst)
      {ov, cry0, cry1, fov, fxu, divChk, fpd} == flagModel)
    else begin
      recordFailure("flags", 32'($sampled({ov, cry0, cry1, fov, fxu, divChk, fpd})),
                    32'($sampled(flagModel)));
      $error("flag register mismatch");
    end

endmodule

bind scdCore scdCore_assert uChk (.*);

`default_nettype wire

// ==== src/scdCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module scdCore (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [scdPkg::funcWidth-1:0]     scadFunc,
  input  logic [scdPkg::scadaSelWidth-1:0] scadaSel,
  input  logic [scdPkg::scadbSelWidth-1:0] scadbSel,
  input  logic                             scSel,
  input  logic                             scmAlt,
  input  logic                             feLoad,
  input  logic                             condFeShrt,
  input  logic                             condAdFlags,
  input  logic                             condPcfMagic,
  input  logic                             condArExp,
  input  logic                             specFlagCtl,
  input  logic                             specClrFpd,
  input  logic                             piCycle,
  input  scdPkg::magicT                    magic,
  input  logic [0:scdPkg::arWidth-1]       ar,
  input  logic                             adOverflow,
  input  logic                             adCry0,
  input  logic                             adCry1,
  output logic [0:scdPkg::scadWidth-1]     scad,
  output logic                             scadZero,
  output logic [0:scdPkg::scadWidth-1]     fe,
  output logic [0:scdPkg::scadWidth-1]     sc,
  output logic                             scGe36,
  output logic                             sc36To63,
  output logic                             ov,
  output logic                             cry0,
  output logic                             cry1,
  output logic                             fov,
  output logic                             fxu,
  output logic                             divChk,
  output logic                             fpd
);

  logic [scdPkg::aluSelWidth-1:0]   aluSel;
  logic                             carryIn;
  logic                             aluMode;
  logic [scdPkg::scadaSelWidth-1:0] scadaSrc;
  logic [scdPkg::scadbSelWidth-1:0] scadbSrc;
  logic [scdPkg::feModeWidth-1:0]   feMode;
  logic [scdPkg::scmWidth-1:0]      scSrc;
  logic                             setAdFlags;
  logic                             pcfMagic;
  logic                             expTest;
  logic                             loadFlags;
  logic                             clrFpd;
  logic                             scadSign;

  scdDecode uDecode (
    .scadFunc(scadFunc), .scadaSel(scadaSel), .scadbSel(scadbSel),
    .scSel(scSel), .scmAlt(scmAlt), .feLoad(feLoad), .condFeShrt(condFeShrt),
    .condAdFlags(condAdFlags), .condPcfMagic(condPcfMagic), .condArExp(condArExp),
    .specFlagCtl(specFlagCtl), .specClrFpd(specClrFpd), .piCycle(piCycle),
    .magic(magic), .aluSel(aluSel), .carryIn(carryIn), .aluMode(aluMode),
    .scadaSrc(scadaSrc), .scadbSrc(scadbSrc), .feMode(feMode), .scSrc(scSrc),
    .setAdFlags(setAdFlags), .pcfMagic(pcfMagic), .expTest(expTest),
    .loadFlags(loadFlags), .clrFpd(clrFpd)
  );

  scadAlu uAlu (
    .aluSel(aluSel), .carryIn(carryIn), .aluMode(aluMode),
    .scadaSel(scadaSrc), .scadbSel(scadbSrc), .ar(ar), .magic(magic),
    .fe(fe), .sc(sc), .scad(scad), .scadSign(scadSign), .scadZero(scadZero)
  );

  scdRegs uRegs (
    .clk(clk), .rst(rst), .feMode(feMode), .scSrc(scSrc), .scad(scad), .ar(ar),
    .fe(fe), .sc(sc), .scGe36(scGe36), .sc36To63(sc36To63)
  );

  pcFlags uFlags (
    .clk(clk), .rst(rst), .setAdFlags(setAdFlags), .pcfMagic(pcfMagic),
    .expTest(expTest), .loadFlags(loadFlags), .clrFpd(clrFpd),
    .adOverflow(adOverflow), .adCry0(adCry0), .adCry1(adCry1),
    .scad(scad), .scadSign(scadSign), .ar(ar), .magic(magic),
    .ov(ov), .cry0(cry0), .cry1(cry1), .fov(fov), .fxu(fxu),
    .divChk(divChk), .fpd(fpd)
  );

endmodule

`default_nettype wire

// ==== src/pcFlags.sv ====
`timescale 1ns/1ps
`default_nettype none

module pcFlags (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         setAdFlags,
  input  logic                         pcfMagic,
  input  logic                         expTest,
  input  logic                         loadFlags,
  input  logic                         clrFpd,
  input  logic                         adOverflow,
  input  logic                         adCry0,
  input  logic                         adCry1,
  input  logic [0:scdPkg::scadWidth-1] scad,
  input  logic                         scadSign,
  input  logic [0:scdPkg::arWidth-1]   ar,
  input  scdPkg::magicT                magic,
  output logic                         ov,
  output logic                         cry0,
  output logic                         cry1,
  output logic                         fov,
  output logic                         fxu,
  output logic                         divChk,
  output logic                         fpd
);

  logic expOvSet;
  logic magicOvSet;
  logic ovSet;
  logic cry0Set;
  logic cry1Set;
  logic fovSet;
  logic fxuSet;
  logic divChkSet;
  logic fpdSet;

  // Exponent overflow shows in SCAD bit 1
  assign expOvSet = expTest & scad[1];
  assign magicOvSet = pcfMagic & magic.flags.ovSet;

  assign ovSet = (setAdFlags & adOverflow) | expOvSet | magicOvSet;
  assign cry0Set = setAdFlags & adCry0;
  assign cry1Set = setAdFlags & adCry1;
  assign fovSet = expOvSet | magicOvSet;
  assign fxuSet = (expTest & scadSign) | (pcfMagic & magic.flags.fxuSet);
  assign divChkSet = pcfMagic & magic.flags.divChkSet;
  assign fpdSet = pcfMagic & magic.flags.fpdSet;

  always_ff @(posedge clk) begin
    if (rst) begin
      ov <= 1'b0;
      cry0 <= 1'b0;
      cry1 <= 1'b0;
      fov <= 1'b0;
      fxu <= 1'b0;
      divChk <= 1'b0;
      fpd <= 1'b0;
    end else if (loadFlags) begin
      // PC word flag layout
      ov <= ar[0];
      cry0 <= ar[1];
      cry1 <= ar[2];
      fov <= ar[3];
      fxu <= ar[11];
      divChk <= ar[12];
      fpd <= ar[4];
    end else begin
      ov <= ov | ovSet;
      cry0 <= cry0 | cry0Set;
      cry1 <= cry1 | cry1Set;
      fov <= fov | fovSet;
      fxu <= fxu | fxuSet;
      divChk <= divChk | divChkSet;
      // Set beats clear in the same cycle
      fpd <= fpdSet | (fpd & ~clrFpd);
    end
  end

endmodule

`default_nettype wire

// ==== src/scdRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

module scdRegs (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [scdPkg::feModeWidth-1:0] feMode,
  input  logic [scdPkg::scmWidth-1:0]    scSrc,
  input  logic [0:scdPkg::scadWidth-1]   scad,
  input  logic [0:scdPkg::arWidth-1]     ar,
  output logic [0:scdPkg::scadWidth-1]   fe,
  output logic [0:scdPkg::scadWidth-1]   sc,
  output logic                           scGe36,
  output logic                           sc36To63
);

  logic [0:scdPkg::scadWidth-1] arLow;

  assign arLow = ar[scdPkg::arWidth-scdPkg::scadWidth:scdPkg::arWidth-1];

  // FE shifts right with sign fill
  always_ff @(posedge clk) begin
    if (rst) begin
      fe <= '0;
    end else begin
      case (feMode)
        scdPkg::feModeLoad: begin
          fe <= scad;
        end
        scdPkg::feModeShift: begin
          fe <= {fe[0], fe[0:scdPkg::scadWidth-2]};
        end
        default: begin
          fe <= fe;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      sc <= '0;
    end else begin
      case (scSrc)
        scdPkg::scmFe: begin
          sc <= fe;
        end
        scdPkg::scmScad: begin
          sc <= scad;
        end
        scdPkg::scmAr: begin
          sc <= arLow;
        end
        default: begin
          sc <= sc;
        end
      endcase
    end
  end

  // Shift count range tests for the shifter
  assign scGe36 = |sc[0:3];
  assign sc36To63 = sc[4] & (|sc[5:7]);

endmodule

`default_nettype wire

// ==== src/scadAlu.sv ====
`timescale 1ns/1ps
`default_nettype none

module scadAlu (
  input  logic [scdPkg::aluSelWidth-1:0]   aluSel,
  input  logic                             carryIn,
  input  logic                             aluMode,
  input  logic [scdPkg::scadaSelWidth-1:0] scadaSel,
  input  logic [scdPkg::scadbSelWidth-1:0] scadbSel,
  input  logic [0:scdPkg::arWidth-1]       ar,
  input  scdPkg::magicT                    magic,
  input  logic [0:scdPkg::scadWidth-1]     fe,
  input  logic [0:scdPkg::scadWidth-1]     sc,
  output logic [0:scdPkg::scadWidth-1]     scad,
  output logic                             scadSign,
  output logic                             scadZero
);

  logic [0:7]                       expField;
  logic [0:scdPkg::scadWidth-1]     magicExt;
  logic [0:scdPkg::scadWidth-1]     scadA;
  logic [0:scdPkg::scadWidth-1]     scadB;
  logic [4:0]                       lowRes;
  logic [4:0]                       midRes;
  logic [4:0]                       topRes;

  // One 4-bit adder slice, result is {carry out, F}
  function automatic logic [4:0] slice(input logic [3:0] a, input logic [3:0] b,
                                       input logic [3:0] sel, input logic mode,
                                       input logic cin);
    logic [3:0] bTerm;
    logic [4:0] res;
    begin
      bTerm = '0;
      res = '0;
      if (mode) begin
        case (sel)
          scdPkg::selOr:  res = {1'b0, a | b};
          scdPkg::selAnd: res = {1'b0, a & b};
          default:        res = {1'b0, a};
        endcase
      end else begin
        case (sel)
          scdPkg::selNotB:   bTerm = ~b;
          scdPkg::selPlusB:  bTerm = b;
          scdPkg::selMinus1: bTerm = 4'hf;
          default:           bTerm = 4'h0;
        endcase
        res = {1'b0, a} + {1'b0, bTerm} + {4'b0, cin};
      end
      slice = res;
    end
  endfunction

  // Exponent in magnitude form for negative numbers
  assign expField = ar[1:8] ^ {8{ar[0]}};
  assign magicExt = {magic.value[0], magic.value};

  always_comb begin
    scadA = '0;
    if (!scadaSel[scdPkg::scadaSelWidth-1]) begin
      case (scadaSel)
        scdPkg::scadaFe:    scadA = fe;
        scdPkg::scadaPos:   scadA = {4'b0, ar[0:5]};
        scdPkg::scadaExp:   scadA = {2'b0, expField};
        scdPkg::scadaMagic: scadA = magicExt;
        default:            scadA = '0;
      endcase
    end
  end

  always_comb begin
    case (scadbSel)
      scdPkg::scadbSc:     scadB = sc;
      scdPkg::scadbSize:   scadB = {4'b0, ar[6:11]};
      scdPkg::scadbArLeft: scadB = {ar[0], ar[0:8]};
      default:             scadB = magicExt;
    endcase
  end

  // Top slice carries a duplicated sign bit to form SCAD sign
  assign lowRes = slice(scadA[6:9], scadB[6:9], aluSel, aluMode, carryIn);
  assign midRes = slice(scadA[2:5], scadB[2:5], aluSel, aluMode, lowRes[4]);
  assign topRes = slice({1'b0, scadA[0], scadA[0], scadA[1]},
                        {1'b0, scadB[0], scadB[0], scadB[1]},
                        aluSel, aluMode, midRes[4]);

  assign scad = {topRes[1:0], midRes[3:0], lowRes[3:0]};
  assign scadSign = topRes[2];
  assign scadZero = (scad == '0);

endmodule

`default_nettype wire

// ==== src/scdDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module scdDecode (
  input  logic [scdPkg::funcWidth-1:0]     scadFunc,
  input  logic [scdPkg::scadaSelWidth-1:0] scadaSel,
  input  logic [scdPkg::scadbSelWidth-1:0] scadbSel,
  input  logic                             scSel,
  input  logic                             scmAlt,
  input  logic                             feLoad,
  input  logic                             condFeShrt,
  input  logic                             condAdFlags,
  input  logic                             condPcfMagic,
  input  logic                             condArExp,
  input  logic                             specFlagCtl,
  input  logic                             specClrFpd,
  input  logic                             piCycle,
  input  scdPkg::magicT                    magic,
  output logic [scdPkg::aluSelWidth-1:0]   aluSel,
  output logic                             carryIn,
  output logic                             aluMode,
  output logic [scdPkg::scadaSelWidth-1:0] scadaSrc,
  output logic [scdPkg::scadbSelWidth-1:0] scadbSrc,
  output logic [scdPkg::feModeWidth-1:0]   feMode,
  output logic [scdPkg::scmWidth-1:0]      scSrc,
  output logic                             setAdFlags,
  output logic                             pcfMagic,
  output logic                             expTest,
  output logic                             loadFlags,
  output logic                             clrFpd
);

  // SCAD function to slice selects, boolean mode only for OR and AND
  always_comb begin
    aluSel = scdPkg::selPassA;
    carryIn = 1'b0;
    aluMode = 1'b0;
    case (scadFunc)
      scdPkg::fnA:     aluSel = scdPkg::selPassA;
      scdPkg::fnAmBm1: aluSel = scdPkg::selNotB;
      scdPkg::fnApB:   aluSel = scdPkg::selPlusB;
      scdPkg::fnAm1:   aluSel = scdPkg::selMinus1;
      scdPkg::fnAp1: begin
        aluSel = scdPkg::selPassA;
        carryIn = 1'b1;
      end
      scdPkg::fnAmB: begin
        aluSel = scdPkg::selNotB;
        carryIn = 1'b1;
      end
      scdPkg::fnOr: begin
        aluSel = scdPkg::selOr;
        aluMode = 1'b1;
      end
      default: begin
        aluSel = scdPkg::selAnd;
        carryIn = 1'b1;
        aluMode = 1'b1;
      end
    endcase
  end

  assign scadaSrc = scadaSel;
  assign scadbSrc = scadbSel;

  // Load wins over shift
  always_comb begin
    if (feLoad) begin
      feMode = scdPkg::feModeLoad;
    end else if (condFeShrt) begin
      feMode = scdPkg::feModeShift;
    end else begin
      feMode = scdPkg::feModeHold;
    end
  end

  assign scSrc = {scSel, scmAlt};

  // No flag updates during a PI cycle
  assign setAdFlags = condAdFlags & ~piCycle;
  assign pcfMagic = condPcfMagic & ~piCycle;
  assign expTest = condArExp & ~piCycle;

  assign loadFlags = specFlagCtl & magic.flags.loadFlagsSel;
  assign clrFpd = specClrFpd;

endmodule

`default_nettype wire

// ==== src/scdPkg.sv ====
`default_nettype none

package scdPkg;

  localparam int scadWidth = 10;
  localparam int magicWidth = 9;
  localparam int arWidth = 36;

  localparam int funcWidth = 3;
  localparam int scadaSelWidth = 3;
  localparam int scadbSelWidth = 2;
  localparam int scmWidth = 2;
  localparam int feModeWidth = 2;
  localparam int aluSelWidth = 4;

  // SCAD function field
  localparam logic [funcWidth-1:0] fnA = 3'd0;
  localparam logic [funcWidth-1:0] fnAmBm1 = 3'd1;
  localparam logic [funcWidth-1:0] fnApB = 3'd2;
  localparam logic [funcWidth-1:0] fnAm1 = 3'd3;
  localparam logic [funcWidth-1:0] fnAp1 = 3'd4;
  localparam logic [funcWidth-1:0] fnAmB = 3'd5;
  localparam logic [funcWidth-1:0] fnOr = 3'd6;
  localparam logic [funcWidth-1:0] fnAnd = 3'd7;

  // Top bit of the SCADA field disables the selector
  localparam logic [scadaSelWidth-1:0] scadaFe = 3'd0;
  localparam logic [scadaSelWidth-1:0] scadaPos = 3'd1;
  localparam logic [scadaSelWidth-1:0] scadaExp = 3'd2;
  localparam logic [scadaSelWidth-1:0] scadaMagic = 3'd3;

  localparam logic [scadbSelWidth-1:0] scadbSc = 2'd0;
  localparam logic [scadbSelWidth-1:0] scadbSize = 2'd1;
  localparam logic [scadbSelWidth-1:0] scadbArLeft = 2'd2;
  localparam logic [scadbSelWidth-1:0] scadbMagic = 2'd3;

  localparam logic [scmWidth-1:0] scmHold = 2'd0;
  localparam logic [scmWidth-1:0] scmFe = 2'd1;
  localparam logic [scmWidth-1:0] scmScad = 2'd2;
  localparam logic [scmWidth-1:0] scmAr = 2'd3;

  localparam logic [feModeWidth-1:0] feModeHold = 2'd0;
  localparam logic [feModeWidth-1:0] feModeLoad = 2'd1;
  localparam logic [feModeWidth-1:0] feModeShift = 2'd2;

  // Adder slice select lines, S8 S4 S2 S1
  localparam logic [aluSelWidth-1:0] selPassA = 4'b0000;
  localparam logic [aluSelWidth-1:0] selNotB = 4'b1001;
  localparam logic [aluSelWidth-1:0] selPlusB = 4'b0110;
  localparam logic [aluSelWidth-1:0] selMinus1 = 4'b0111;
  localparam logic [aluSelWidth-1:0] selOr = 4'b0100;
  localparam logic [aluSelWidth-1:0] selAnd = 4'b1110;

  // Magic field, bit 0 is the top bit
  typedef union packed {
    logic [0:magicWidth-1] value;
    struct packed {
      logic ovSet;
      logic clrUser;
      logic fpdSet;
      logic trap2Unused;
      logic loadFlagsSel;
      logic fxuSet;
      logic divChkSet;
      logic kernelKeep;
      logic spare;
    } flags;
  } magicT;

endpackage

`default_nettype wire
